//--- av_golden.txt
# H cmd data | L user disk power led | A signed core_l core_r linux_l linux_r exp_l exp_r
# M signed mix count (random, model checked) | S csync_on ; all values hex
L 1 1 1 15
H 25 f0a5
L 1 0 1 a1
H 33 00ff
L 1 0 1 a1
H 25 0000
L 0 1 1 14
A 1 1000 f000 0234 0010 1234 f010
A 0 8000 fffe 0100 0001 4100 7fff
A 1 7000 9000 2000 c000 7fff 8000
M 1 0 4
M 1 1 4
M 1 2 4
M 1 3 4
M 0 3 4
H 26 0002
M 1 1 4
H 26 0007
M 1 2 4
H 26 0010
M 1 3 4
H 26 0000
M 0 0 4
S 0
H 01 0008
S 1
H 01 0000
S 0

//--- compile.f
+incdir+.
av_pkg.sv
host_cfg_regs.sv
sync_polarity_fix.sv
csync_gen.sv
video_sync_out.sv
audio_mix_channel.sv
av_sys_top.sv
tb_av_sys_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AV platform testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_av_sys_top -o tb_av_sim

./obj_dir/tb_av_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

//--- tb_av_checks.svh
/*
 * Error counters and typed compare tasks
 * One compare task per result kind of the AV platform
 */

// Wrong values, missing handshakes, golden file problems
int value_errs = 0;
int ack_errs   = 0;
int file_errs  = 0;

////////////////////////////// LED byte
task automatic check_led(
	input string                    name,
	input logic [av_pkg::LED_W-1:0] got,
	input logic [av_pkg::LED_W-1:0] exp
);
	if (got !== exp) begin
		value_errs++;
		$display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

////////////////////////////// Audio sample
task automatic check_sample(
	input string           name,
	input av_pkg::sample_t got,
	input av_pkg::sample_t exp
);
	if (got !== exp) begin
		value_errs++;
		$display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

////////////////////////////// Sync bit
task automatic check_bit(
	input string name,
	input logic  got,
	input logic  exp
);
	if (got !== exp) begin
		value_errs++;
		$display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

//--- tb_av_sys_top.sv
/*
 * Testbench for the AV platform top level
 * Golden file reader, host writes, audio model, sync checks and watchdog
 */

module tb_av_sys_top;

	localparam int CLK_P     = 40;
	localparam int DRV       = 2;
	localparam int LINE_LEN  = 32;
	localparam int HS_LEN    = 4;
	localparam int FRAME_LN  = 8;
	localparam int VS_LN     = 2;
	localparam int FRAME_CYC = LINE_LEN * FRAME_LN;
	localparam int SYNC_CYC  = 4 * FRAME_CYC;

	logic                     clk;
	logic                     resetd;
	logic                     io_uio;
	logic                     io_clk;
	av_pkg::host_word_t       io_din;
	logic                     led_user;
	logic                     led_disk;
	logic                     led_power;
	logic                     hs;
	logic                     vs;
	av_pkg::mix_t             mix;
	logic                     is_signed;
	av_pkg::sample_t          core_l;
	av_pkg::sample_t          core_r;
	av_pkg::sample_t          linux_l;
	av_pkg::sample_t          linux_r;
	logic                     io_ack;
	logic [av_pkg::LED_W-1:0] led;
	logic                     o_hs;
	logic                     o_vs;
	logic                     o_cs;
	av_pkg::sample_t          audio_l;
	av_pkg::sample_t          audio_r;

	string        tags[$];
	logic [15:0]  fields[$];
	int           timeout_cyc = 0;
	int           seed = 73714;
	av_pkg::att_t cur_att = '0;

	`include "tb_av_checks.svh"

	av_sys_top dut (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (io_uio),
		.i_io_clk    (io_clk),
		.i_io_din    (io_din),
		.i_led_user  (led_user),
		.i_led_disk  (led_disk),
		.i_led_power (led_power),
		.i_hs        (hs),
		.i_vs        (vs),
		.i_mix       (mix),
		.i_is_signed (is_signed),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_linux_l   (linux_l),
		.i_linux_r   (linux_r),
		.o_io_ack    (io_ack),
		.o_led       (led),
		.o_hs        (o_hs),
		.o_vs        (o_vs),
		.o_cs        (o_cs),
		.o_audio_l   (audio_l),
		.o_audio_r   (audio_r)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_P / 2) clk = ~clk;
	end

	////////////////////////////// Golden file
	function automatic int field_count(input string tag);
		case (tag)
			"H": return 2;
			"L": return 4;
			"A": return 7;
			"M": return 3;
			"S": return 1;
			default: return 0;
		endcase
	endfunction

	task automatic load_golden();
		int          fd;
		int          code;
		int          nf;
		string       tag;
		string       line;
		logic [15:0] v;
		fd = $fopen("av_golden.txt", "r");
		if (fd == 0) begin
			file_errs++;
			$display("Could not open av_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tag);
				if (code == 1 && tag == "#") begin
					code = $fgets(line, fd);
				end else if (code == 1) begin
					nf = field_count(tag);
					if (nf == 0) begin
						file_errs++;
						$display("Unknown record type %s in golden file", tag);
					end else begin
						tags.push_back(tag);
						for (int i = 0; i < nf; i++) begin
							code = $fscanf(fd, "%h", v);
							fields.push_back(v);
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////// Mixer reference model
	function automatic int sum_ref(input logic sgn, input av_pkg::sample_t core,
		input av_pkg::sample_t lin);
		int conv;
		if (sgn)
			conv = int'(core);
		else
			conv = int'({1'b0, core[15:1]});
		return conv + int'(lin);
	endfunction

	function automatic av_pkg::sample_t mix_ref(input int own, input int other,
		input av_pkg::mix_t mode, input av_pkg::att_t att);
		int pre_o;
		int m;
		// Pre-mix value is the channel sum halved
		pre_o = other >>> 1;
		case (mode)
			av_pkg::MIX_LOW:  m = own - (own >>> 3) + (pre_o >>> 2);
			av_pkg::MIX_MID:  m = own - (own >>> 2) + (pre_o >>> 1);
			av_pkg::MIX_MONO: m = (own >>> 1) + pre_o;
			default:          m = own;
		endcase
		if (att[4])
			m = 0;
		else
			m = m >>> att[3:0];
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		return av_pkg::sample_t'(m);
	endfunction

	////////////////////////////// Host port
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (io_ack !== level && n < 64) begin
			@(posedge clk);
			#DRV;
			n++;
		end
		if (io_ack !== level) begin
			ack_errs++;
			$display("Host write stalled, acknowledge never went %0d", level);
		end
	endtask

	task automatic write_word(input av_pkg::host_word_t w);
		io_din = w;
		io_clk = 1'b1;
		wait_ack(1'b1);
		io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic host_write(input logic [7:0] cmd, input av_pkg::host_word_t data);
		io_uio = 1'b1;
		repeat (3) @(posedge clk);
		#DRV;
		write_word({8'h00, cmd});
		write_word(data);
		io_uio = 1'b0;
		repeat (4) @(posedge clk);
		#DRV;
		if (cmd == av_pkg::CMD_VOL)
			cur_att = data[4:0];
	endtask

	////////////////////////////// Audio
	task automatic drive_audio(input logic sgn, input av_pkg::mix_t m,
		input av_pkg::sample_t cl, input av_pkg::sample_t cr,
		input av_pkg::sample_t ll, input av_pkg::sample_t lr);
		is_signed = sgn;
		mix       = m;
		core_l    = cl;
		core_r    = cr;
		linux_l   = ll;
		linux_r   = lr;
		repeat (16) @(posedge clk);
		#DRV;
	endtask

	task automatic random_audio(input logic sgn, input av_pkg::mix_t m, input int count);
		av_pkg::sample_t cl;
		av_pkg::sample_t cr;
		av_pkg::sample_t ll;
		av_pkg::sample_t lr;
		int              sl;
		int              sr;
		for (int i = 0; i < count; i++) begin
			cl = av_pkg::sample_t'($random(seed));
			cr = av_pkg::sample_t'($random(seed));
			ll = av_pkg::sample_t'($random(seed));
			lr = av_pkg::sample_t'($random(seed));
			drive_audio(sgn, m, cl, cr, ll, lr);
			sl = sum_ref(sgn, cl, ll);
			sr = sum_ref(sgn, cr, lr);
			check_sample("o_audio_l", audio_l, mix_ref(sl, sr, m, cur_att));
			check_sample("o_audio_r", audio_r, mix_ref(sr, sl, m, cur_att));
		end
	endtask

	////////////////////////////// Video sync
	// Active-low sync in, active-high out two cycles later
	task automatic run_sync(input logic csync);
		logic h1;
		logic h2;
		logic v1;
		logic v2;
		h1 = hs;
		h2 = hs;
		v1 = vs;
		v2 = vs;
		for (int t = 0; t < SYNC_CYC; t++) begin
			if (t >= 2 * FRAME_CYC) begin
				check_bit("o_vs", o_vs, ~v2);
				if (csync) begin
					check_bit("o_hs", o_hs, o_cs);
					if (v2)
						check_bit("o_cs", o_cs, ~h2);
				end else begin
					check_bit("o_hs", o_hs, ~h2);
				end
			end
			h2 = h1;
			v2 = v1;
			hs = ((t % LINE_LEN) < HS_LEN) ? 1'b0 : 1'b1;
			vs = (((t / LINE_LEN) % FRAME_LN) < VS_LN) ? 1'b0 : 1'b1;
			h1 = hs;
			v1 = vs;
			@(posedge clk);
			#DRV;
		end
	endtask

	////////////////////////////// Main sequence
	initial begin
		int fp;
		int nsync;
		resetd    = 1'b1;
		io_uio    = 1'b0;
		io_clk    = 1'b0;
		io_din    = '0;
		led_user  = 1'b1;
		led_disk  = 1'b0;
		led_power = 1'b1;
		hs        = 1'b1;
		vs        = 1'b1;
		mix       = av_pkg::MIX_NONE;
		is_signed = 1'b1;
		core_l    = '0;
		core_r    = '0;
		linux_l   = '0;
		linux_r   = '0;

		load_golden();
		nsync = 0;
		foreach (tags[i])
			if (tags[i] == "S")
				nsync++;
		timeout_cyc = tags.size() * 400 + nsync * SYNC_CYC + 200;

		repeat (8) @(posedge clk);
		#DRV;
		resetd = 1'b0;
		@(posedge clk);
		#DRV;

		check_bit("o_io_ack", io_ack, 1'b0);
		check_bit("o_hs", o_hs, 1'b0);
		check_bit("o_vs", o_vs, 1'b0);
		check_bit("o_cs", o_cs, 1'b0);
		check_sample("o_audio_l", audio_l, '0);
		check_sample("o_audio_r", audio_r, '0);
		check_led("o_led", led, 8'h11);

		fp = 0;
		foreach (tags[i]) begin
			case (tags[i])
				"H": host_write(fields[fp][7:0], fields[fp+1]);
				"L": begin
					led_user  = fields[fp][0];
					led_disk  = fields[fp+1][0];
					led_power = fields[fp+2][0];
					#1;
					check_led("o_led", led, fields[fp+3][7:0]);
				end
				"A": begin
					drive_audio(fields[fp][0], av_pkg::MIX_NONE, fields[fp+1],
						fields[fp+2], fields[fp+3], fields[fp+4]);
					check_sample("o_audio_l", audio_l, fields[fp+5]);
					check_sample("o_audio_r", audio_r, fields[fp+6]);
				end
				"M": random_audio(fields[fp][0], av_pkg::mix_t'(fields[fp+1][1:0]),
					int'(fields[fp+2]));
				"S": run_sync(fields[fp][0]);
				default: ;
			endcase
			fp += field_count(tags[i]);
		end

		$display("Errors: %0d value, %0d handshake, %0d golden file",
			value_errs, ack_errs, file_errs);
		if (value_errs + ack_errs + file_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog sized from the golden records once they are loaded
	initial begin
		wait (timeout_cyc > 0);
		repeat (timeout_cyc) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not finish", timeout_cyc);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- av_sys_top.sv
/*
 * AV platform top level
 * Host registers, video sync path and the stereo mixer pair
 */

module av_sys_top #(
	parameter int SYNC_CNT_W_P = av_pkg::SYNC_CNT_W
) (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_uio,
	input  logic                     i_io_clk,
	input  av_pkg::host_word_t       i_io_din,
	input  logic                     i_led_user,
	input  logic                     i_led_disk,
	input  logic                     i_led_power,
	input  logic                     i_hs,
	input  logic                     i_vs,
	input  av_pkg::mix_t             i_mix,
	input  logic                     i_is_signed,
	input  av_pkg::sample_t          i_core_l,
	input  av_pkg::sample_t          i_core_r,
	input  av_pkg::sample_t          i_linux_l,
	input  av_pkg::sample_t          i_linux_r,
	output logic                     o_io_ack,
	output logic [av_pkg::LED_W-1:0] o_led,
	output logic                     o_hs,
	output logic                     o_vs,
	output logic                     o_cs,
	output av_pkg::sample_t          o_audio_l,
	output av_pkg::sample_t          o_audio_r
);

	av_pkg::att_t    att;
	logic            csync_en;
	av_pkg::sample_t pre_l;
	av_pkg::sample_t pre_r;

	host_cfg_regs u_regs (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.i_led_user  (i_led_user),
		.i_led_disk  (i_led_disk),
		.i_led_power (i_led_power),
		.o_io_ack    (o_io_ack),
		.o_att       (att),
		.o_csync_en  (csync_en),
		.o_led       (o_led)
	);

	video_sync_out #(.SYNC_CNT_W_P(SYNC_CNT_W_P)) u_video (
		.clk        (clk),
		.resetd     (resetd),
		.i_hs       (i_hs),
		.i_vs       (i_vs),
		.i_csync_en (csync_en),
		.o_hs       (o_hs),
		.o_vs       (o_vs),
		.o_cs       (o_cs)
	);

	// Channels swap their pre-mix values for the stereo blend
	audio_mix_channel u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (i_core_l),
		.i_linux     (i_linux_l),
		.i_pre       (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_channel u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (i_core_r),
		.i_linux     (i_linux_r),
		.i_pre       (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

endmodule

//--- audio_mix_channel.sv
/*
 * One audio mixer channel
 * Glitch filter, core/Linux sum, stereo blend, attenuation and clamp
 */

module audio_mix_channel (
	input  logic            clk,
	input  logic            resetd,
	input  av_pkg::att_t    i_att,
	input  av_pkg::mix_t    i_mix,
	input  logic            i_is_signed,
	input  av_pkg::sample_t i_core,
	input  av_pkg::sample_t i_linux,
	input  av_pkg::sample_t i_pre,
	output av_pkg::sample_t o_pre,
	output av_pkg::sample_t o_out
);

	localparam int SW         = av_pkg::SAMPLE_W;
	// Mute reaches o_out after the attenuation and clamp stages
	localparam int MUTE_DEPTH = 2;

	av_pkg::sample_t      core_d1;
	av_pkg::sample_t      core_d2;
	av_pkg::sample_t      core_d3;
	av_pkg::sample_t      core_flt;
	av_pkg::wide_sample_t conv_q;
	av_pkg::wide_sample_t sum_q;
	av_pkg::wide_sample_t mix_q;
	av_pkg::wide_sample_t att_q;

	////////////////////////////// Glitch filter
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1  <= '0;
			core_d2  <= '0;
			core_d3  <= '0;
			core_flt <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			// Only a sample seen twice in a row gets through
			if (core_d2 == core_d3)
				core_flt <= core_d2;
		end
	end

	////////////////////////////// Mix pipeline
	always_ff @(posedge clk) begin
		if (resetd) begin
			conv_q <= '0;
			sum_q  <= '0;
			mix_q  <= '0;
			att_q  <= '0;
			o_pre  <= '0;
			o_out  <= '0;
		end else begin
			// Unsigned core audio is halved into the positive range
			if (i_is_signed)
				conv_q <= av_pkg::wide_sample_t'(core_flt);
			else
				conv_q <= av_pkg::wide_sample_t'({2'b00, core_flt[SW-1:1]});

			sum_q <= conv_q + av_pkg::wide_sample_t'(i_linux);
			o_pre <= sum_q[SW:1];

			case (i_mix)
				av_pkg::MIX_NONE: mix_q <= sum_q;
				av_pkg::MIX_LOW:  mix_q <= sum_q - (sum_q >>> 3)
					+ av_pkg::wide_sample_t'(i_pre >>> 2);
				av_pkg::MIX_MID:  mix_q <= sum_q - (sum_q >>> 2)
					+ av_pkg::wide_sample_t'(i_pre >>> 1);
				av_pkg::MIX_MONO: mix_q <= (sum_q >>> 1)
					+ av_pkg::wide_sample_t'(i_pre);
				default:          mix_q <= sum_q;
			endcase

			if (i_att[av_pkg::ATT_MUTE_BIT])
				att_q <= '0;
			else
				att_q <= mix_q >>> i_att[av_pkg::ATT_MUTE_BIT-1:0];

			// Saturate to 16 bits when the top two bits disagree
			if (att_q[SW] ^ att_q[SW-1])
				o_out <= {att_q[SW], {(SW-1){att_q[SW-1]}}};
			else
				o_out <= att_q[SW-1:0];
		end
	end

	a_mute_silent: assert property (@(posedge clk) disable iff (resetd)
		i_att[av_pkg::ATT_MUTE_BIT] [*MUTE_DEPTH] |=> (o_out == '0));

endmodule

//--- video_sync_out.sv
/*
 * Video sync output stage
 * Polarity fixers, composite sync and aligned HS/VS/CS selection
 */

module video_sync_out #(
	parameter int SYNC_CNT_W_P = av_pkg::SYNC_CNT_W
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync_en,
	output logic o_hs,
	output logic o_vs,
	output logic o_cs
);

	logic hs_fix;
	logic vs_fix;
	logic cs_raw;
	logic hs_d;
	logic vs_d;

	sync_polarity_fix #(.SYNC_CNT_W_P(SYNC_CNT_W_P)) u_fix_h (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_hs),
		.o_sync (hs_fix)
	);

	sync_polarity_fix #(.SYNC_CNT_W_P(SYNC_CNT_W_P)) u_fix_v (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_vs),
		.o_sync (vs_fix)
	);

	csync_gen #(.SYNC_CNT_W_P(SYNC_CNT_W_P)) u_csync (
		.clk    (clk),
		.resetd (resetd),
		.i_hs   (hs_fix),
		.i_vs   (vs_fix),
		.o_cs   (cs_raw)
	);

	// Separate path gets one extra stage to match the composite register
	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_d <= 1'b0;
			vs_d <= 1'b0;
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_cs <= 1'b0;
		end else begin
			hs_d <= hs_fix;
			vs_d <= vs_fix;
			o_vs <= vs_d;
			o_hs <= i_csync_en ? cs_raw : hs_d;
			o_cs <= cs_raw;
		end
	end

endmodule

//--- csync_gen.sv
/*
 * Composite sync generator
 * Outside vsync follows hsync, during vsync shifts it one hsync period early
 */

module csync_gen #(
	parameter int SYNC_CNT_W_P = av_pkg::SYNC_CNT_W
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_cs
);

	logic                    prev_hs;
	logic [SYNC_CNT_W_P-1:0] h_cnt;
	// Point in the low phase one hsync length before the next pulse
	logic [SYNC_CNT_W_P-1:0] line_len;
	logic [SYNC_CNT_W_P-1:0] hs_len;
	logic                    cs_hs;
	logic                    cs_vs;
	logic [1:0]              lines_seen;

	always_ff @(posedge clk) begin
		if (resetd) begin
			prev_hs    <= 1'b0;
			h_cnt      <= '0;
			line_len   <= '0;
			hs_len     <= '0;
			cs_hs      <= 1'b0;
			cs_vs      <= 1'b0;
			lines_seen <= '0;
		end else begin
			prev_hs <= i_hs;
			h_cnt   <= h_cnt + 1'b1;

			if (prev_hs ^ i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
					if (lines_seen != 2'd3)
						lines_seen <= lines_seen + 1'b1;
				end else begin
					hs_len <= h_cnt;
				end
			end

			// Serration pulses during vsync
			if (~i_vs)
				cs_hs <= i_hs;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;

			cs_vs <= i_vs;
		end
	end

	assign o_cs = cs_vs ^ cs_hs;

	// Once two lines are measured the shift point is real
	a_line_len_valid: assert property (@(posedge clk) disable iff (resetd)
		(i_vs && lines_seen == 2'd3) |-> (line_len != '0));

endmodule

//--- sync_polarity_fix.sv
/*
 * Sync polarity correction
 * Measures both phases and inverts so the pulse is the short, high phase
 */

module sync_polarity_fix #(
	parameter int SYNC_CNT_W_P = av_pkg::SYNC_CNT_W
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                    s1;
	logic                    s2;
	logic [SYNC_CNT_W_P-1:0] cnt;
	logic [SYNC_CNT_W_P-1:0] hi_len;
	logic [SYNC_CNT_W_P-1:0] lo_len;
	logic                    invert;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			invert <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Rising edge ends a low phase, falling edge a high phase
			if (s1 & ~s2)
				lo_len <= cnt;
			if (~s1 & s2)
				hi_len <= cnt;

			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;

			invert <= hi_len > lo_len;
		end
	end

	assign o_sync = i_sync ^ invert;

endmodule

//--- host_cfg_regs.sv
/*
 * Host port synchronizer, strobe and acknowledge
 * Command decoder with config, LED override and volume registers
 * Status LED combiner
 */

module host_cfg_regs (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_uio,
	input  logic                     i_io_clk,
	input  av_pkg::host_word_t       i_io_din,
	input  logic                     i_led_user,
	input  logic                     i_led_disk,
	input  logic                     i_led_power,
	output logic                     o_io_ack,
	output av_pkg::att_t             o_att,
	output logic                     o_csync_en,
	output logic [av_pkg::LED_W-1:0] o_led
);

	logic                      uio_d;
	logic                      uio_r;
	logic                      clk_d;
	logic                      clk_r;
	av_pkg::host_word_t        din_d;
	av_pkg::host_word_t        din_r;
	logic                      ack_q;
	logic                      strobe;
	logic                      has_cmd;
	av_pkg::host_cmd_t         cmd;
	logic [av_pkg::LED_W-1:0]  led_overtake;
	logic [av_pkg::LED_W-1:0]  led_state;
	logic [av_pkg::LED_W-1:0]  led_dflt;

	////////////////////////////// Host sync
	// Data word follows the strobe through the same two stages
	always_ff @(posedge clk) begin
		din_d <= i_io_din;
		din_r <= din_d;
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			uio_d <= 1'b0;
			uio_r <= 1'b0;
			clk_d <= 1'b0;
			clk_r <= 1'b0;
		end else begin
			uio_d <= i_io_uio;
			uio_r <= uio_d;
			clk_d <= i_io_clk;
			clk_r <= clk_d;
		end
	end

	// Ack tracks the host strobe level, so a strobe is one cycle wide
	assign strobe = clk_r & ~ack_q;

	always_ff @(posedge clk) begin
		if (resetd)
			ack_q <= 1'b0;
		else
			ack_q <= clk_r;
	end

	assign o_io_ack = ack_q;

	////////////////////////////// Command decoder
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= av_pkg::host_cmd_t'(0);
			o_att        <= '0;
			o_csync_en   <= 1'b0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!uio_r) begin
			// Dropping select makes the next word a command again
			has_cmd <= 1'b0;
			cmd     <= av_pkg::host_cmd_t'(0);
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= av_pkg::host_cmd_t'(din_r[av_pkg::CMD_W-1:0]);
			end else begin
				case (cmd)
					av_pkg::CMD_CFG: o_csync_en <= din_r[av_pkg::CFG_CSYNC_BIT];
					av_pkg::CMD_LED: {led_overtake, led_state} <= din_r;
					av_pkg::CMD_VOL: o_att <= din_r[av_pkg::ATT_W-1:0];
					// Unknown commands swallow their data
					default: ;
				endcase
			end
		end
	end

	////////////////////////////// LEDs
	always_comb begin
		led_dflt    = '0;
		led_dflt[0] = i_led_user;
		led_dflt[2] = i_led_disk;
		led_dflt[4] = i_led_power;
		for (int i = 0; i < av_pkg::LED_W; i++) begin
			o_led[i] = led_overtake[i] ? led_state[i] : led_dflt[i];
		end
	end

	// Acknowledge only answers a strobe taken while select is high
	a_ack_needs_strobe: assert property (@(posedge clk) disable iff (resetd)
		$rose(o_io_ack) |-> $past(strobe && uio_r));

endmodule

//--- av_pkg.sv
/*
 * Shared types and widths for the AV platform
 * Audio samples, attenuation, stereo mix modes, host words and commands
 */

package av_pkg;

	////////////////////////////// Audio
	localparam int SAMPLE_W = 16;

	// Mixer sample and one bit of headroom for the sums
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SAMPLE_W:0]   wide_sample_t;

	// Attenuation: bit 4 mutes, bits 3..0 are the right shift
	localparam int ATT_W        = 5;
	localparam int ATT_MUTE_BIT = 4;
	typedef logic [ATT_W-1:0] att_t;

	// Stereo blend between the two channels
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_MONO = 2'd3
	} mix_t;

	////////////////////////////// Host port
	localparam int HOST_W = 16;
	localparam int CMD_W  = 8;
	localparam int LED_W  = 8;

	typedef logic [HOST_W-1:0] host_word_t;

	// Command byte, first word after select rises
	typedef enum logic [CMD_W-1:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} host_cmd_t;

	// Config word bit that switches HS to composite sync
	localparam int CFG_CSYNC_BIT = 3;

	////////////////////////////// Video
	// Sync measurement counters, wide enough for a full line
	localparam int SYNC_CNT_W = 16;

endpackage
